// ==== design/cpuPkg.sv ====
package cpuPkg;

    localparam int wordWidth = 32;  // Data path and bus width
    localparam int regCount  = 16;  // General registers R0..R15

    typedef logic [3:0] regIndexT;

    // Opcode values occupy instruction bits 31..27
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opMul  = 5'd7,
        opMfhi = 5'd8,
        opMflo = 5'd9,
        opHalt = 5'd10
    } opcodeT;

    // Instruction field positions
    localparam int opMsb  = 31;
    localparam int opLsb  = 27;
    localparam int raMsb  = 26;  // Destination, or source for st
    localparam int raLsb  = 23;
    localparam int rbMsb  = 22;  // First ALU operand
    localparam int rbLsb  = 19;
    localparam int rcMsb  = 18;  // Second ALU operand
    localparam int rcLsb  = 15;
    localparam int immMsb = 14;  // Immediate or memory address
    localparam int immLsb = 0;

endpackage

// ==== design/ctrlPkg.sv ====
package ctrlPkg;

    // Control steps of the sequencer
    typedef enum logic [3:0] {
        stepT0,
        stepT1,
        stepT2,
        stepT3,
        stepT4,
        stepT5,
        stepT6,
        stepMemWait,  // APB transfer in flight
        stepHalted
    } stepT;

    // Register that drives the shared bus
    typedef enum logic [2:0] {
        srcPc,
        srcMdr,
        srcZlow,
        srcZhigh,
        srcReg,   // Register file, or HI/LO for mfhi and mflo
        srcImm    // Sign-extended immediate from IR
    } busSrcT;

endpackage

// ==== design/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf #(
    parameter int addrWidth = 15
);
    import cpuPkg::*;
    import ctrlPkg::*;

    busSrcT   busSrc;
    regIndexT regOutSel, regInSel;
    logic     regIn, hiIn, loIn;
    logic     pcIn, incPc, irIn, marIn;
    logic     mdrIn, mdrFromMem;  // MDR loads from prdata when mdrFromMem is set
    logic     yIn, zIn;
    opcodeT   aluOp;

    // Status from the datapath
    logic [wordWidth-1:0] ir;
    logic [addrWidth-1:0] mar;
    logic [wordWidth-1:0] mdr;

    modport seq (output busSrc, regOutSel, regInSel, regIn, hiIn, loIn, pcIn, incPc,
                 irIn, marIn, mdrIn, mdrFromMem, yIn, zIn, aluOp,
                 input ir, mar, mdr);

    modport dp (input busSrc, regOutSel, regInSel, regIn, hiIn, loIn, pcIn, incPc,
                irIn, marIn, mdrIn, mdrFromMem, yIn, zIn, aluOp,
                output ir, mar, mdr);

endinterface

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                            Clock,
    input  logic                            rst,
    input  cpuPkg::regIndexT                readSel,
    output logic [cpuPkg::wordWidth-1:0]    readData,
    input  cpuPkg::regIndexT                writeSel,
    input  logic                            writeEn,
    input  logic                            hiIn,
    input  logic                            loIn,
    input  logic [cpuPkg::wordWidth-1:0]    writeData,
    input  logic [2*cpuPkg::wordWidth-1:0]  hiLoData,
    output logic [cpuPkg::wordWidth-1:0]    hiData,
    output logic [cpuPkg::wordWidth-1:0]    loData
);
    import cpuPkg::*;

    logic [wordWidth-1:0] regs [regCount];

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
            hiData <= '0;
            loData <= '0;
        end else begin
            if (writeEn) begin
                regs[writeSel] <= writeData;
            end
            // HI and LO take their halves of the 64-bit Z value
            if (hiIn) begin
                hiData <= hiLoData[2*wordWidth-1:wordWidth];
            end
            if (loIn) begin
                loData <= hiLoData[wordWidth-1:0];
            end
        end
    end

    assign readData = regs[readSel];  // Combinational read onto the bus

endmodule

// ==== design/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::opcodeT                  op,
    input  logic [cpuPkg::wordWidth-1:0]    a,
    input  logic [cpuPkg::wordWidth-1:0]    b,
    output logic [2*cpuPkg::wordWidth-1:0]  result
);
    import cpuPkg::*;

    logic signed [2*wordWidth-1:0] aWide, bWide;
    logic signed [2*wordWidth-1:0] product;
    logic        [wordWidth-1:0]   sum, diff;

    // Sign extension happens on assignment to the wide signed operands
    assign aWide   = signed'(a);
    assign bWide   = signed'(b);
    assign product = aWide * bWide;

    assign sum  = a + b;  // Wraps at 32 bits
    assign diff = a - b;

    always_comb begin
        case (op)
            opAdd: begin
                result = {{wordWidth{1'b0}}, sum};
            end
            opSub: begin
                result = {{wordWidth{1'b0}}, diff};
            end
            opAnd: begin
                result = {{wordWidth{1'b0}}, a & b};
            end
            opOr: begin
                result = {{wordWidth{1'b0}}, a | b};
            end
            opMul: begin
                result = product;  // Full signed product for HI:LO
            end
            default: begin
                result = {{wordWidth{1'b0}}, b};  // Pass the bus through
            end
        endcase
    end

endmodule

// ==== design/datapath.sv ====
`timescale 1ns/1ps

module datapath #(
    parameter int addrWidth = 15
) (
    input  logic                          Clock,
    input  logic                          rst,
    ctrlIf.dp                             ctrl,
    output logic [addrWidth-1:0]          paddr,
    output logic [cpuPkg::wordWidth-1:0]  pwdata,
    input  logic [cpuPkg::wordWidth-1:0]  prdata
);
    import cpuPkg::*;
    import ctrlPkg::*;

    localparam int immWidth = immMsb - immLsb + 1;

    logic [wordWidth-1:0]   bus;
    logic [wordWidth-1:0]   readData, hiData, loData;
    logic [wordWidth-1:0]   regValue;
    logic [wordWidth-1:0]   y, aluA;
    logic [2*wordWidth-1:0] z, aluResult;
    logic [addrWidth-1:0]   pc;

    regFile i_regFile (
        .Clock     (Clock),
        .rst       (rst),
        .readSel   (ctrl.regOutSel),
        .readData  (readData),
        .writeSel  (ctrl.regInSel),
        .writeEn   (ctrl.regIn),
        .hiIn      (ctrl.hiIn),
        .loIn      (ctrl.loIn),
        .writeData (bus),
        .hiLoData  (z),
        .hiData    (hiData),
        .loData    (loData)
    );

    // Increment path feeds a constant 1 in place of Y
    assign aluA = ctrl.incPc ? wordWidth'(1) : y;

    aluUnit i_aluUnit (
        .op     (ctrl.aluOp),
        .a      (aluA),
        .b      (bus),
        .result (aluResult)
    );

    // mfhi and mflo reach HI and LO through the register source
    always_comb begin
        case (ctrl.aluOp)
            opMfhi:  regValue = hiData;
            opMflo:  regValue = loData;
            default: regValue = readData;
        endcase
    end

    // Shared bus
    always_comb begin
        case (ctrl.busSrc)
            srcPc:    bus = wordWidth'(pc);
            srcMdr:   bus = ctrl.mdr;
            srcZlow:  bus = z[wordWidth-1:0];
            srcZhigh: bus = z[2*wordWidth-1:wordWidth];
            srcReg:   bus = regValue;
            srcImm:   bus = {{(wordWidth-immWidth){ctrl.ir[immMsb]}}, ctrl.ir[immMsb:immLsb]};
            default:  bus = '0;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            pc      <= '0;
            ctrl.ir <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus[addrWidth-1:0];
            end
            if (ctrl.irIn) begin
                ctrl.ir <= bus;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (ctrl.marIn) begin
            ctrl.mar <= bus[addrWidth-1:0];
        end
        if (ctrl.mdrIn) begin
            ctrl.mdr <= ctrl.mdrFromMem ? prdata : bus;
        end
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
    end

    assign paddr  = ctrl.mar;  // Held during the whole APB transfer
    assign pwdata = ctrl.mdr;

endmodule

// ==== design/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer #(
    parameter int addrWidth = 15
) (
    input  logic Clock,
    input  logic rst,
    ctrlIf.seq   ctrl,
    output logic psel,
    output logic penable,
    output logic pwrite,
    input  logic pready,
    output logic halted
);
    import cpuPkg::*;
    import ctrlPkg::*;

    stepT   step, nextStep;
    stepT   retStep, nextRetStep;  // Step that follows stepMemWait
    opcodeT opcode;
    logic   startRead, startWrite;
    logic   apbDone;

    // PC and MAR load from the bus, so an address must fit in a word
    if (addrWidth > wordWidth) begin : gAddrCheck
        $error("addrWidth exceeds the bus width");
    end

    assign opcode  = opcodeT'(ctrl.ir[opMsb:opLsb]);
    assign apbDone = psel & penable & pready;
    assign halted  = (step == stepHalted);

    always_ff @(posedge Clock) begin
        if (rst) begin
            step    <= stepT0;
            retStep <= stepT0;
            psel    <= 1'b0;
            penable <= 1'b0;
            pwrite  <= 1'b0;
        end else begin
            step    <= nextStep;
            retStep <= nextRetStep;
            if (startRead || startWrite) begin
                psel   <= 1'b1;  // Setup phase next cycle
                pwrite <= startWrite;
            end else if (apbDone) begin
                psel    <= 1'b0;
                penable <= 1'b0;
                pwrite  <= 1'b0;
            end else if (psel) begin
                penable <= 1'b1;  // Access phase, held until pready
            end
        end
    end

    always_comb begin
        ctrl.busSrc     = srcPc;
        ctrl.regOutSel  = ctrl.ir[rbMsb:rbLsb];
        ctrl.regInSel   = ctrl.ir[raMsb:raLsb];
        ctrl.regIn      = 1'b0;
        ctrl.hiIn       = 1'b0;
        ctrl.loIn       = 1'b0;
        ctrl.pcIn       = 1'b0;
        ctrl.incPc      = 1'b0;
        ctrl.irIn       = 1'b0;
        ctrl.marIn      = 1'b0;
        ctrl.mdrIn      = 1'b0;
        ctrl.mdrFromMem = 1'b0;
        ctrl.yIn        = 1'b0;
        ctrl.zIn        = 1'b0;
        ctrl.aluOp      = opcode;
        nextStep        = step;
        nextRetStep     = retStep;
        startRead       = 1'b0;
        startWrite      = 1'b0;

        case (step)
            stepT0: begin  // PC to MAR, PC+1 to Z
                ctrl.busSrc = srcPc;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
                ctrl.zIn    = 1'b1;
                ctrl.aluOp  = opAdd;
                nextStep    = stepT1;
            end
            stepT1: begin
                ctrl.busSrc = srcZlow;
                ctrl.pcIn   = 1'b1;
                startRead   = 1'b1;  // Instruction fetch
                nextRetStep = stepT2;
                nextStep    = stepMemWait;
            end
            stepMemWait: begin
                if (apbDone) begin
                    ctrl.mdrIn      = !pwrite;
                    ctrl.mdrFromMem = !pwrite;
                    nextStep        = retStep;
                end
            end
            stepT2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irIn   = 1'b1;
                nextStep    = stepT3;
            end
            stepT3: begin
                case (opcode)
                    opAdd, opSub, opAnd, opOr, opMul: begin
                        ctrl.busSrc = srcReg;  // rb to Y
                        ctrl.yIn    = 1'b1;
                        nextStep    = stepT4;
                    end
                    opLd: begin
                        ctrl.busSrc = srcImm;
                        ctrl.marIn  = 1'b1;
                        startRead   = 1'b1;
                        nextRetStep = stepT5;
                        nextStep    = stepMemWait;
                    end
                    opSt: begin
                        ctrl.busSrc = srcImm;
                        ctrl.marIn  = 1'b1;
                        nextStep    = stepT4;
                    end
                    opLdi: begin
                        ctrl.busSrc = srcImm;
                        ctrl.regIn  = 1'b1;
                        nextStep    = stepT0;
                    end
                    opMfhi, opMflo: begin
                        ctrl.busSrc = srcReg;  // aluOp picks HI or LO
                        ctrl.regIn  = 1'b1;
                        nextStep    = stepT0;
                    end
                    opHalt:  nextStep = stepHalted;
                    default: nextStep = stepT0;  // Unknown opcode acts as a no-op
                endcase
            end
            stepT4: begin
                ctrl.busSrc = srcReg;
                if (opcode == opSt) begin
                    ctrl.regOutSel = ctrl.ir[raMsb:raLsb];  // Store data into MDR
                    ctrl.mdrIn     = 1'b1;
                    startWrite     = 1'b1;
                    nextRetStep    = stepT0;
                    nextStep       = stepMemWait;
                end else begin
                    ctrl.regOutSel = ctrl.ir[rcMsb:rcLsb];
                    ctrl.zIn       = 1'b1;
                    nextStep       = stepT5;
                end
            end
            stepT5: begin
                if (opcode == opLd) begin
                    ctrl.busSrc = srcMdr;
                    ctrl.regIn  = 1'b1;
                    nextStep    = stepT0;
                end else if (opcode == opMul) begin
                    ctrl.busSrc = srcZlow;
                    ctrl.loIn   = 1'b1;
                    nextStep    = stepT6;
                end else begin
                    ctrl.busSrc = srcZlow;
                    ctrl.regIn  = 1'b1;
                    nextStep    = stepT0;
                end
            end
            stepT6: begin  // Upper product half
                ctrl.busSrc = srcZhigh;
                ctrl.hiIn   = 1'b1;
                nextStep    = stepT0;
            end
            stepHalted: nextStep = stepHalted;  // Only reset leaves this step
            default:    nextStep = stepT0;
        endcase
    end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop #(
    parameter int addrWidth = 15
) (
    input  logic                          Clock,
    input  logic                          rst,
    output logic [addrWidth-1:0]          paddr,
    output logic                          psel,
    output logic                          penable,
    output logic                          pwrite,
    output logic [cpuPkg::wordWidth-1:0]  pwdata,
    input  logic [cpuPkg::wordWidth-1:0]  prdata,
    input  logic                          pready,
    output logic                          halted
);

    ctrlIf #(.addrWidth(addrWidth)) ctrlBus ();

    // Step machine and APB requester
    controlSequencer #(.addrWidth(addrWidth)) i_controlSequencer (
        .Clock   (Clock),
        .rst     (rst),
        .ctrl    (ctrlBus.seq),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pready  (pready),
        .halted  (halted)
    );

    datapath #(.addrWidth(addrWidth)) i_datapath (
        .Clock  (Clock),
        .rst    (rst),
        .ctrl   (ctrlBus.dp),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata)
    );

endmodule

// ==== tb/cpuChecker.sv ====
`timescale 1ns/1ps

module cpuChecker #(
    parameter int addrWidth = 15
) (
    input logic                          Clock,
    input logic                          rst,
    input logic                          psel,
    input logic                          penable,
    input logic                          pwrite,
    input logic                          pready,
    input logic                          halted,
    input logic [addrWidth-1:0]          paddr,
    input logic [cpuPkg::wordWidth-1:0]  pwdata
);

    int assertErrors = 0;  // Failed assertions, summed up by cpuTb

    // Requester is idle while reset is applied
    resetIdle: assert property (@(posedge Clock)
        rst |=> !psel && !penable && !pwrite && !halted)
    else begin
        assertErrors++;
        $error("APB outputs or halted not low during reset");
    end

    // Exactly one setup cycle before each access phase
    setupThenAccess: assert property (@(posedge Clock) disable iff (rst)
        psel && !penable |=> psel && penable)
    else begin
        assertErrors++;
        $error("APB setup phase not followed by access phase");
    end

    enableNeedsSetup: assert property (@(posedge Clock) disable iff (rst)
        $rose(penable) |-> $past(psel) && !$past(penable))
    else begin
        assertErrors++;
        $error("penable rose without a setup cycle");
    end

    // Address, direction and write data held until completion
    heldUntilDone: assert property (@(posedge Clock) disable iff (rst)
        psel && !(penable && pready) |=>
            psel && $stable(paddr) && $stable(pwrite) && (!pwrite || $stable(pwdata)))
    else begin
        assertErrors++;
        $error("APB transfer changed or dropped before pready");
    end

    haltSticky: assert property (@(posedge Clock) disable iff (rst)
        halted |=> halted)
    else begin
        assertErrors++;
        $error("halted dropped without reset");
    end

    haltNoBus: assert property (@(posedge Clock) disable iff (rst)
        halted |-> !psel)
    else begin
        assertErrors++;
        $error("APB transfer started after halt");
    end

endmodule

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int addrWidth   = 15;
    localparam int clkPeriod   = 100;
    localparam int memDepth    = 256;
    localparam int worstCycles = 15;  // ld with three wait states on fetch and load

    logic                 Clock, rst;
    logic [addrWidth-1:0] paddr;
    logic                 psel, penable, pwrite, pready, halted;
    logic [wordWidth-1:0] pwdata, prdata;

    logic [wordWidth-1:0] mem [memDepth];
    logic [wordWidth-1:0] refRegs [regCount];
    logic [wordWidth-1:0] refHi, refLo;
    int                   expAddr[$];
    logic [wordWidth-1:0] expData[$];
    int                   progLen, storeCount, tbErrors, waitLeft;
    logic                 programReady, sawFirstRead;
    logic [31:0]          rngState;

    cpuTop #(.addrWidth(addrWidth)) i_cpuTop (
        .Clock   (Clock),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .halted  (halted)
    );

    bind cpuTop cpuChecker #(.addrWidth(addrWidth)) i_cpuChecker (
        .Clock   (Clock),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pready  (pready),
        .halted  (halted),
        .paddr   (paddr),
        .pwdata  (pwdata)
    );

    always #(clkPeriod / 2) Clock = ~Clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            tbErrors++;
            $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Writes one instruction and steps the reference model through it
    task automatic addInstr(input opcodeT op, input int ra, input int rb, input int rc,
                            input int imm);
        logic [wordWidth-1:0]   immExt;
        logic signed [63:0]     aWide, bWide, product;
        immExt = {{17{imm[14]}}, imm[14:0]};
        mem[progLen] = {op, ra[3:0], rb[3:0], rc[3:0], imm[14:0]};
        progLen++;
        aWide   = $signed({{32{refRegs[rb][31]}}, refRegs[rb]});
        bWide   = $signed({{32{refRegs[rc][31]}}, refRegs[rc]});
        product = aWide * bWide;
        case (op)
            opLdi:  refRegs[ra] = immExt;
            opLd:   refRegs[ra] = mem[imm];
            opAdd:  refRegs[ra] = refRegs[rb] + refRegs[rc];
            opSub:  refRegs[ra] = refRegs[rb] - refRegs[rc];
            opAnd:  refRegs[ra] = refRegs[rb] & refRegs[rc];
            opOr:   refRegs[ra] = refRegs[rb] | refRegs[rc];
            opMfhi: refRegs[ra] = refHi;
            opMflo: refRegs[ra] = refLo;
            opMul: begin
                refHi = product[63:32];
                refLo = product[31:0];
            end
            opSt: begin
                expAddr.push_back(imm);
                expData.push_back(refRegs[ra]);
            end
            default: ;
        endcase
    endtask

    task automatic buildProgram();
        mem[200] = 32'hdead_beef;
        mem[201] = 32'h7fff_0123;
        addInstr(opLdi, 1, 0, 0, 1234);
        addInstr(opLdi, 2, 0, 0, -77);
        addInstr(opLd, 3, 0, 0, 200);
        addInstr(opLd, 4, 0, 0, 201);
        addInstr(opAdd, 5, 1, 3, 0);
        addInstr(opSub, 6, 2, 4, 0);
        addInstr(opAnd, 7, 3, 4, 0);
        addInstr(opOr, 8, 1, 2, 0);
        addInstr(opMul, 0, 3, 4, 0);
        addInstr(opMfhi, 9, 0, 0, 0);
        addInstr(opMflo, 10, 0, 0, 0);
        for (int r = 1; r <= 10; r++) begin
            addInstr(opSt, r, 0, 0, 209 + r);  // Every result to its own word
        end
        addInstr(opHalt, 0, 0, 0, 0);
    endtask

    task automatic completeTransfer();
        pready = 1'b1;
        assert (paddr < memDepth) else begin
            tbErrors++;
            $display("APB access at %0t lies outside the memory model", $time);
        end
        if (pwrite) begin
            assert (storeCount < expAddr.size()) else begin
                tbErrors++;
                $display("Store at %0t was not expected by the program", $time);
            end
            if (storeCount < expAddr.size()) begin
                checkValue("paddr", expAddr[storeCount], 32'(paddr));
                checkValue("pwdata", expData[storeCount], pwdata);
            end
            mem[paddr[7:0]] = pwdata;
            storeCount++;
        end else begin
            prdata = mem[paddr[7:0]];
        end
    endtask

    // APB completer with 0 to 3 wait states per transfer
    always @(posedge Clock) begin
        #1;
        pready = 1'b0;
        if (!rst && psel && !penable) begin
            rngState = xorshift32(rngState);
            waitLeft = rngState[1:0];
            if (!sawFirstRead) begin
                checkValue("pwrite", 0, 32'(pwrite));
                checkValue("paddr", 0, 32'(paddr));  // Fetch starts at PC 0
                sawFirstRead = 1'b1;
            end
        end else if (!rst && psel && penable) begin
            if (waitLeft > 0) begin
                waitLeft--;
            end else begin
                completeTransfer();
            end
        end
    end

    task automatic checkIdle();
        checkValue("psel", 0, 32'(psel));
        checkValue("penable", 0, 32'(penable));
        checkValue("pwrite", 0, 32'(pwrite));
        checkValue("halted", 0, 32'(halted));
    endtask

    initial begin
        wait (programReady);
        #((progLen * worstCycles + 3) * 2 * clkPeriod);
        $display("Timeout: the core did not halt in time");
        $display("Errors: testbench %0d, checker %0d", tbErrors,
                 i_cpuTop.i_cpuChecker.assertErrors);
        $display("Regression failed");
        $finish;
    end

    initial begin
        Clock        = 1'b0;
        rst          = 1'b1;
        prdata       = '0;
        pready       = 1'b0;
        progLen      = 0;
        storeCount   = 0;
        tbErrors     = 0;
        waitLeft     = 0;
        sawFirstRead = 1'b0;
        programReady = 1'b0;
        rngState     = 32'h9799;
        refHi        = '0;
        refLo        = '0;
        for (int i = 0; i < memDepth; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < regCount; i++) begin
            refRegs[i] = '0;
        end
        buildProgram();
        programReady = 1'b1;

        repeat (3) begin
            @(posedge Clock);
            #1;
            checkIdle();
        end
        rst = 1'b0;
        @(posedge Clock);
        #1;
        checkIdle();  // In T1, fetch transfer not yet started

        wait (halted === 1'b1);
        repeat (5) begin
            @(posedge Clock);
            #1;
            checkValue("halted", 1, 32'(halted));
            checkValue("psel", 0, 32'(psel));
        end
        checkValue("storeCount", expAddr.size(), storeCount);

        $display("Errors: testbench %0d, checker %0d", tbErrors,
                 i_cpuTop.i_cpuChecker.assertErrors);
        if (tbErrors == 0 && i_cpuTop.i_cpuChecker.assertErrors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/cpuPkg.sv
design/ctrlPkg.sv
design/ctrlIf.sv
design/regFile.sv
design/aluUnit.sv
design/datapath.sv
design/controlSequencer.sv
design/cpuTop.sv
tb/cpuChecker.sv
tb/cpuTb.sv
